/* pov_display_top.f */
source/pov_geom_pkg.sv
source/hub75_pkg.sv
source/column_if.sv
source/angle_timer.sv
source/polar_frame_store.sv
source/rot_frame_buffer_to_hub75.sv
source/hub75_shifter.sv
source/pov_display_top.sv
testbench/pov_display_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= pov_display_tb
FILELIST  ?= pov_display_top.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

/* testbench/pov_display_tb.sv */
`default_nettype none

module pov_display_tb;

  localparam int SLICE_CYCLES = 600;
  localparam int SHIFT_DIV    = 1;
  localparam int NUM_ENTRIES  = 8;
  localparam int WAIT_LIMIT   = 2000;

  logic                    clk_in = 1'b0;
  logic                    rst_in;
  logic                    index_pulse;
  logic                    wr_en;
  pov_geom_pkg::theta_t    wr_theta;
  pov_geom_pkg::radius_t   wr_radius0;
  pov_geom_pkg::radius_t   wr_radius1;
  pov_geom_pkg::row_bits_t wr_col0;
  pov_geom_pkg::row_bits_t wr_col1;
  logic                    hub75_r1;
  logic                    hub75_g1;
  logic                    hub75_b1;
  logic                    hub75_r2;
  logic                    hub75_g2;
  logic                    hub75_b2;
  logic                    hub75_clk;
  logic                    hub75_lat;
  logic                    hub75_oe;
  pov_geom_pkg::radius_t   hub75_addr;

  // Stimulus table with one slice in each entry
  pov_geom_pkg::theta_t    tab_theta   [NUM_ENTRIES];
  pov_geom_pkg::radius_t   tab_radius0 [NUM_ENTRIES];
  pov_geom_pkg::radius_t   tab_radius1 [NUM_ENTRIES];
  pov_geom_pkg::row_bits_t tab_col0    [NUM_ENTRIES];
  pov_geom_pkg::row_bits_t tab_col1    [NUM_ENTRIES];
  integer                  seed = 96456;

  // Frames seen on the panel pins hold channels r1 g1 b1 r2 g2 b2 at index 0 to 5
  pov_geom_pkg::row_bits_t [5:0] frame_q [$];
  pov_geom_pkg::radius_t         addr_q [$];
  int                            lat_cycle_q [$];
  pov_geom_pkg::row_bits_t [5:0] cur_frame;
  int                            cycle_no = 0;
  int                            pix_cnt = 0;
  int                            prev_latch_cycle = 0;
  logic                          clk_prev = 1'b0;
  logic                          lat_prev = 1'b0;

  always #10 clk_in = ~clk_in;

  pov_display_top #(
    .SLICE_CYCLES (SLICE_CYCLES),
    .SHIFT_DIV    (SHIFT_DIV)
  ) u_dut (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .index_pulse (index_pulse),
    .wr_en       (wr_en),
    .wr_theta    (wr_theta),
    .wr_radius0  (wr_radius0),
    .wr_radius1  (wr_radius1),
    .wr_col0     (wr_col0),
    .wr_col1     (wr_col1),
    .hub75_r1    (hub75_r1),
    .hub75_g1    (hub75_g1),
    .hub75_b1    (hub75_b1),
    .hub75_r2    (hub75_r2),
    .hub75_g2    (hub75_g2),
    .hub75_b2    (hub75_b2),
    .hub75_clk   (hub75_clk),
    .hub75_lat   (hub75_lat),
    .hub75_oe    (hub75_oe),
    .hub75_addr  (hub75_addr)
  );

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_bits(input string name, input pov_geom_pkg::row_bits_t got,
                            input pov_geom_pkg::row_bits_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input pov_geom_pkg::radius_t got,
                            input pov_geom_pkg::radius_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic string chan_name(input int ch);
    case (ch)
      0: return "hub75_r1";
      1: return "hub75_g1";
      2: return "hub75_b1";
      3: return "hub75_r2";
      4: return "hub75_g2";
      default: return "hub75_b2";
    endcase
  endfunction

  // Pixels are taken on each rising panel clock and the address on the latch
  always @(posedge clk_in) begin
    cycle_no++;
    if (!rst_in) begin
      if (hub75_clk === 1'b1 && clk_prev === 1'b0) begin
        if (pix_cnt < pov_geom_pkg::NUM_ROWS) begin
          cur_frame[0][pix_cnt] = hub75_r1;
          cur_frame[1][pix_cnt] = hub75_g1;
          cur_frame[2][pix_cnt] = hub75_b1;
          cur_frame[3][pix_cnt] = hub75_r2;
          cur_frame[4][pix_cnt] = hub75_g2;
          cur_frame[5][pix_cnt] = hub75_b2;
        end
        pix_cnt++;
      end
      if (lat_prev === 1'b1) begin
        check_level("hub75_oe", hub75_oe, 1'b0);
      end
      if (hub75_lat === 1'b1) begin
        check_level("hub75_oe", hub75_oe, 1'b1);
        if (pix_cnt != pov_geom_pkg::NUM_ROWS) begin
          $display("Latch at t=%0t came after %0d pixel clocks instead of a full column",
                   $time, pix_cnt);
          abort_run();
        end
        frame_q.push_back(cur_frame);
        addr_q.push_back(hub75_addr);
        lat_cycle_q.push_back(cycle_no);
        pix_cnt = 0;
      end
    end
    clk_prev = hub75_clk;
    lat_prev = hub75_lat;
  end

  task automatic build_table();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      tab_theta[i]   = pov_geom_pkg::theta_t'(3 * i / 2);
      tab_radius0[i] = pov_geom_pkg::radius_t'($random(seed));
      tab_radius1[i] = pov_geom_pkg::radius_t'($random(seed));
      tab_col0[i]    = {$random(seed), $random(seed)};
      tab_col1[i]    = {$random(seed), $random(seed)};
    end
    tab_col0[0]    = '1;
    tab_col1[0]    = '0;
    tab_col0[1]    = {32{2'b01}};
    tab_col1[1]    = {32{2'b10}};
    tab_radius0[1] = '1;
    tab_radius1[1] = '1;
  endtask

  task automatic write_slice(input pov_geom_pkg::theta_t theta,
                             input pov_geom_pkg::radius_t r0, input pov_geom_pkg::radius_t r1,
                             input pov_geom_pkg::row_bits_t c0,
                             input pov_geom_pkg::row_bits_t c1);
    @(posedge clk_in);
    wr_en      <= 1'b1;
    wr_theta   <= theta;
    wr_radius0 <= r0;
    wr_radius1 <= r1;
    wr_col0    <= c0;
    wr_col1    <= c1;
  endtask

  task automatic end_write();
    @(posedge clk_in);
    wr_en <= 1'b0;
  endtask

  // No slice strobe while the rotor is held at index, so the panel must stay dark
  task automatic check_idle();
    check_level("hub75_oe", hub75_oe, 1'b1);
    check_level("hub75_clk", hub75_clk, 1'b0);
    check_level("hub75_lat", hub75_lat, 1'b0);
  endtask

  task automatic pulse_index();
    @(posedge clk_in);
    index_pulse <= 1'b1;
    @(posedge clk_in);
    index_pulse <= 1'b0;
  endtask

  task automatic wait_frames(input int count);
    int waited;
    waited = 0;
    while (frame_q.size() < count && waited < WAIT_LIMIT) begin
      @(posedge clk_in);
      waited++;
    end
    if (frame_q.size() < count) begin
      $display("Timeout at t=%0t: the panel stopped latching frames", $time);
      abort_run();
    end
  endtask

  task automatic check_slice(input logic first, input pov_geom_pkg::radius_t r0,
                             input pov_geom_pkg::radius_t r1,
                             input pov_geom_pkg::row_bits_t c0,
                             input pov_geom_pkg::row_bits_t c1);
    pov_geom_pkg::row_bits_t [5:0] got_a;
    pov_geom_pkg::row_bits_t [5:0] got_b;
    pov_geom_pkg::radius_t         mirrored;
    int                            lat_a;
    int                            lat_b;
    int                            ch;
    wait_frames(2);
    got_a = frame_q.pop_front();
    got_b = frame_q.pop_front();
    lat_a = lat_cycle_q.pop_front();
    lat_b = lat_cycle_q.pop_front();
    mirrored = pov_geom_pkg::radius_t'(pov_geom_pkg::SCAN_RATE - 1 - int'(r1));
    for (ch = 0; ch < 3; ch++) begin
      check_bits(chan_name(ch), got_a[ch], '0);
      check_bits(chan_name(ch + 3), got_a[ch + 3], c0);
      check_bits(chan_name(ch), got_b[ch], c1);
      check_bits(chan_name(ch + 3), got_b[ch + 3], '0);
    end
    check_addr("hub75_addr", addr_q.pop_front(), r0);
    check_addr("hub75_addr", addr_q.pop_front(), mirrored);
    if (!first && (lat_a - prev_latch_cycle != SLICE_CYCLES)) begin
      $display("Slice at t=%0t started %0d cycles after the previous one, not one slice period",
               $time, lat_a - prev_latch_cycle);
      abort_run();
    end
    if (lat_b - lat_a >= SLICE_CYCLES) begin
      $display("Second frame at t=%0t fell outside its slice period", $time);
      abort_run();
    end
    prev_latch_cycle = lat_a;
  endtask

  // Slices between table entries carry the all-zero fill
  task automatic run_slices(input int last_entry);
    int entry;
    int slice;
    entry = 0;
    pulse_index();
    for (slice = 0; slice <= int'(tab_theta[last_entry]); slice++) begin
      if (int'(tab_theta[entry]) == slice) begin
        check_slice(slice == 0, tab_radius0[entry], tab_radius1[entry],
                    tab_col0[entry], tab_col1[entry]);
        entry++;
      end else begin
        check_slice(slice == 0, '0, '0, '0, '0);
      end
    end
  endtask

  task automatic change_entry(input int entry);
    tab_radius0[entry] = pov_geom_pkg::radius_t'($random(seed));
    tab_radius1[entry] = pov_geom_pkg::radius_t'($random(seed));
    tab_col0[entry]    = ~tab_col0[entry];
    tab_col1[entry]    = {$random(seed), $random(seed)};
    write_slice(tab_theta[entry], tab_radius0[entry], tab_radius1[entry],
                tab_col0[entry], tab_col1[entry]);
    end_write();
  endtask

  initial begin
    int i;
    rst_in      <= 1'b1;
    index_pulse <= 1'b1;
    wr_en       <= 1'b0;
    wr_theta    <= '0;
    wr_radius0  <= '0;
    wr_radius1  <= '0;
    wr_col0     <= '0;
    wr_col1     <= '0;
    build_table();
    repeat (3) @(posedge clk_in);
    rst_in <= 1'b0;

    // Rotor held at index while the store is loaded
    for (i = 0; i < pov_geom_pkg::ROT_RES; i++) begin
      write_slice(pov_geom_pkg::theta_t'(i), '0, '0, '0, '0);
      check_idle();
    end
    for (i = 0; i < NUM_ENTRIES; i++) begin
      write_slice(tab_theta[i], tab_radius0[i], tab_radius1[i], tab_col0[i], tab_col1[i]);
      check_idle();
    end
    end_write();

    run_slices(NUM_ENTRIES - 1);

    // New data for one angle while the blade keeps turning
    change_entry(2);
    run_slices(2);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* source/pov_display_top.sv */
`default_nettype none

module pov_display_top #(
  parameter int SLICE_CYCLES = 600,
  parameter int SHIFT_DIV    = 1
) (
  input  wire logic                     clk_in,
  input  wire logic                     rst_in,
  input  wire logic                     index_pulse,
  input  wire logic                     wr_en,
  input  wire pov_geom_pkg::theta_t     wr_theta,
  input  wire pov_geom_pkg::radius_t    wr_radius0,
  input  wire pov_geom_pkg::radius_t    wr_radius1,
  input  wire pov_geom_pkg::row_bits_t  wr_col0,
  input  wire pov_geom_pkg::row_bits_t  wr_col1,
  output logic                          hub75_r1,
  output logic                          hub75_g1,
  output logic                          hub75_b1,
  output logic                          hub75_r2,
  output logic                          hub75_g2,
  output logic                          hub75_b2,
  output logic                          hub75_clk,
  output logic                          hub75_lat,
  output logic                          hub75_oe,
  output pov_geom_pkg::radius_t         hub75_addr
);

  logic                          slice_strobe;
  pov_geom_pkg::theta_t          theta;
  pov_geom_pkg::theta_t          rd_theta;
  pov_geom_pkg::radius_t   [1:0] rd_radii;
  pov_geom_pkg::row_bits_t [1:0] rd_cols;

  column_if col_bus ();

  angle_timer #(
    .SLICE_CYCLES (SLICE_CYCLES)
  ) u_angle_timer (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .index_pulse  (index_pulse),
    .slice_strobe (slice_strobe),
    .theta        (theta)
  );

  polar_frame_store u_frame_store (
    .clk_in     (clk_in),
    .wr_en      (wr_en),
    .wr_theta   (wr_theta),
    .wr_radius0 (wr_radius0),
    .wr_radius1 (wr_radius1),
    .wr_col0    (wr_col0),
    .wr_col1    (wr_col1),
    .rd_theta   (rd_theta),
    .rd_radii   (rd_radii),
    .rd_cols    (rd_cols)
  );

  rot_frame_buffer_to_hub75 u_converter (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .slice_strobe (slice_strobe),
    .theta        (theta),
    .rd_theta     (rd_theta),
    .rd_radii     (rd_radii),
    .rd_cols      (rd_cols),
    .col          (col_bus.conv)
  );

  hub75_shifter #(
    .SHIFT_DIV (SHIFT_DIV)
  ) u_shifter (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .col        (col_bus.shifter),
    .hub75_r1   (hub75_r1),
    .hub75_g1   (hub75_g1),
    .hub75_b1   (hub75_b1),
    .hub75_r2   (hub75_r2),
    .hub75_g2   (hub75_g2),
    .hub75_b2   (hub75_b2),
    .hub75_clk  (hub75_clk),
    .hub75_lat  (hub75_lat),
    .hub75_oe   (hub75_oe),
    .hub75_addr (hub75_addr)
  );

endmodule

`default_nettype wire

/* source/hub75_shifter.sv */
`default_nettype none

module hub75_shifter #(
  parameter int SHIFT_DIV = 1
) (
  input  wire logic              clk_in,
  input  wire logic              rst_in,
  column_if.shifter              col,
  output logic                   hub75_r1,
  output logic                   hub75_g1,
  output logic                   hub75_b1,
  output logic                   hub75_r2,
  output logic                   hub75_g2,
  output logic                   hub75_b2,
  output logic                   hub75_clk,
  output logic                   hub75_lat,
  output logic                   hub75_oe,
  output pov_geom_pkg::radius_t  hub75_addr
);

  localparam int DIV_W = (SHIFT_DIV > 1) ? $clog2(SHIFT_DIV) : 1;
  localparam int ROW_W = $clog2(pov_geom_pkg::NUM_ROWS);

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    LATCH
  } shift_state_t;

  shift_state_t state;

  logic [DIV_W-1:0] div_cnt;
  logic [ROW_W-1:0] row;

  hub75_pkg::column_t [1:0] frame_q;
  pov_geom_pkg::radius_t    addr_q;

  // Frame and address are held locally for the whole shift
  always_ff @(posedge clk_in) begin
    if (col.data_valid) begin
      frame_q <= col.columns;
      addr_q  <= col.col_num;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= IDLE;
      div_cnt    <= '0;
      row        <= '0;
      hub75_clk  <= 1'b0;
      hub75_lat  <= 1'b0;
      hub75_oe   <= 1'b1;
      hub75_addr <= '0;
      col.last   <= 1'b0;
    end else begin
      hub75_lat <= 1'b0;
      col.last  <= 1'b0;
      case (state)
        IDLE: begin
          if (col.data_valid) begin
            state     <= SHIFT;
            div_cnt   <= '0;
            row       <= '0;
            hub75_clk <= 1'b0;
          end
        end
        SHIFT: begin
          if (div_cnt == DIV_W'(SHIFT_DIV - 1)) begin
            div_cnt <= '0;
            if (!hub75_clk) begin
              hub75_clk <= 1'b1;
            end else begin
              hub75_clk <= 1'b0;
              if (row == ROW_W'(pov_geom_pkg::NUM_ROWS - 1)) begin
                // Blank while the new line is latched and the address moves
                state      <= LATCH;
                hub75_oe   <= 1'b1;
                hub75_lat  <= 1'b1;
                hub75_addr <= addr_q;
              end else begin
                row <= row + 1'b1;
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        LATCH: begin
          state    <= IDLE;
          hub75_oe <= 1'b0;
          col.last <= 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Only the top bit of each channel reaches the panel
  assign hub75_r1 = frame_q[0][row][hub75_pkg::R_MSB];
  assign hub75_g1 = frame_q[0][row][hub75_pkg::G_MSB];
  assign hub75_b1 = frame_q[0][row][hub75_pkg::B_MSB];
  assign hub75_r2 = frame_q[1][row][hub75_pkg::R_MSB];
  assign hub75_g2 = frame_q[1][row][hub75_pkg::G_MSB];
  assign hub75_b2 = frame_q[1][row][hub75_pkg::B_MSB];

  idle_on_valid_a: assert property (
    @(posedge clk_in) disable iff (rst_in)
    col.data_valid |-> (state == IDLE)
  );

endmodule

`default_nettype wire

/* source/rot_frame_buffer_to_hub75.sv */
`default_nettype none

module rot_frame_buffer_to_hub75 (
  input  wire logic                              clk_in,
  input  wire logic                              rst_in,
  input  wire logic                              slice_strobe,
  input  wire pov_geom_pkg::theta_t              theta,
  output pov_geom_pkg::theta_t                   rd_theta,
  input  wire pov_geom_pkg::radius_t   [1:0]     rd_radii,
  input  wire pov_geom_pkg::row_bits_t [1:0]     rd_cols,
  column_if.conv                                 col
);

  hub75_pkg::conv_state_t state;

  pov_geom_pkg::radius_t   [1:0] radii_q;
  pov_geom_pkg::row_bits_t [1:0] cols_q;

  hub75_pkg::column_t col0_px;
  hub75_pkg::column_t col1_px;
  logic               first_half;

  // Each set bit lights its pixel at full brightness
  function automatic hub75_pkg::column_t expand(input pov_geom_pkg::row_bits_t bits);
    hub75_pkg::column_t px;
    for (int i = 0; i < pov_geom_pkg::NUM_ROWS; i++) begin
      px[i] = bits[i] ? '1 : '0;
    end
    return px;
  endfunction

  assign rd_theta = theta;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= hub75_pkg::LOAD;
    end else begin
      case (state)
        hub75_pkg::LOAD: begin
          if (slice_strobe) begin
            state <= hub75_pkg::SEND_A;
          end
        end
        hub75_pkg::SEND_A: state <= hub75_pkg::WAIT_A;
        hub75_pkg::WAIT_A: begin
          if (col.last) begin
            state <= hub75_pkg::SEND_B;
          end
        end
        hub75_pkg::SEND_B: state <= hub75_pkg::WAIT_B;
        hub75_pkg::WAIT_B: begin
          if (col.last) begin
            state <= hub75_pkg::LOAD;
          end
        end
        default: state <= hub75_pkg::LOAD;
      endcase
    end
  end

  // Store output tracks the angle while idle, and freezes once the slice is taken
  always_ff @(posedge clk_in) begin
    if (state == hub75_pkg::LOAD) begin
      radii_q <= rd_radii;
      cols_q  <= rd_cols;
    end
  end

  assign col0_px    = expand(cols_q[0]);
  assign col1_px    = expand(cols_q[1]);
  assign first_half = (state == hub75_pkg::SEND_A) || (state == hub75_pkg::WAIT_A);

  // First frame lights the lower half, second frame the upper half
  // with its radius mirrored across the scan range
  always_comb begin
    if (first_half) begin
      col.columns[0] = '0;
      col.columns[1] = col0_px;
      col.col_num    = radii_q[0];
    end else begin
      col.columns[0] = col1_px;
      col.columns[1] = '0;
      col.col_num    = pov_geom_pkg::radius_t'(pov_geom_pkg::SCAN_RATE - 1) - radii_q[1];
    end
  end

  assign col.data_valid = (state == hub75_pkg::SEND_A) || (state == hub75_pkg::SEND_B);

  single_valid_a: assert property (
    @(posedge clk_in) disable iff (rst_in)
    col.data_valid |=> !col.data_valid
  );

endmodule

`default_nettype wire

/* source/polar_frame_store.sv */
`default_nettype none

module polar_frame_store (
  input  wire logic                           clk_in,
  input  wire logic                           wr_en,
  input  wire pov_geom_pkg::theta_t           wr_theta,
  input  wire pov_geom_pkg::radius_t          wr_radius0,
  input  wire pov_geom_pkg::radius_t          wr_radius1,
  input  wire pov_geom_pkg::row_bits_t        wr_col0,
  input  wire pov_geom_pkg::row_bits_t        wr_col1,
  input  wire pov_geom_pkg::theta_t           rd_theta,
  output pov_geom_pkg::radius_t   [1:0]       rd_radii,
  output pov_geom_pkg::row_bits_t [1:0]       rd_cols
);

  // Each slice keeps its two radii and its two bitmaps in separate RAMs
  pov_geom_pkg::radius_t   [1:0] radii_mem [pov_geom_pkg::ROT_RES];
  pov_geom_pkg::row_bits_t [1:0] cols_mem  [pov_geom_pkg::ROT_RES];

  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      radii_mem[wr_theta] <= {wr_radius1, wr_radius0};
      cols_mem[wr_theta]  <= {wr_col1, wr_col0};
    end
  end

  // Read data follows rd_theta by one cycle
  always_ff @(posedge clk_in) begin
    rd_radii <= radii_mem[rd_theta];
    rd_cols  <= cols_mem[rd_theta];
  end

  wr_theta_known_a: assert property (
    @(posedge clk_in)
    wr_en |-> !$isunknown(wr_theta)
  );

endmodule

`default_nettype wire

/* source/angle_timer.sv */
`default_nettype none

module angle_timer #(
  parameter int SLICE_CYCLES = 600
) (
  input  wire logic                 clk_in,
  input  wire logic                 rst_in,
  input  wire logic                 index_pulse,
  output logic                      slice_strobe,
  output pov_geom_pkg::theta_t      theta
);

  localparam int CNT_W = (SLICE_CYCLES > 1) ? $clog2(SLICE_CYCLES) : 1;

  logic [CNT_W-1:0] cycle_cnt;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cycle_cnt    <= '0;
      slice_strobe <= 1'b0;
      theta        <= '0;
    end else if (index_pulse) begin
      // Rotor is at its zero position, so restart the slice grid here
      cycle_cnt    <= '0;
      slice_strobe <= 1'b0;
      theta        <= '0;
    end else if (cycle_cnt == CNT_W'(SLICE_CYCLES - 1)) begin
      cycle_cnt    <= '0;
      slice_strobe <= 1'b1;
      if (theta == pov_geom_pkg::theta_t'(pov_geom_pkg::ROT_RES - 1)) begin
        theta <= '0;
      end else begin
        theta <= theta + 1'b1;
      end
    end else begin
      cycle_cnt    <= cycle_cnt + 1'b1;
      slice_strobe <= 1'b0;
    end
  end

  // The angle only ever advances by one slice or snaps back to zero
  theta_step_a: assert property (
    @(posedge clk_in) disable iff (rst_in)
    $changed(theta) |->
      (theta == '0) ||
      (theta == pov_geom_pkg::theta_t'(($past(theta) + 1) % pov_geom_pkg::ROT_RES))
  );

endmodule

`default_nettype wire

/* source/column_if.sv */
`default_nettype none

// Frame handoff from the slice converter to the HUB75 shifter.
// Index 0 of columns feeds the upper half, index 1 the lower half
interface column_if;

  pov_geom_pkg::radius_t col_num;
  hub75_pkg::column_t [1:0] columns;
  logic data_valid;
  logic last;

  modport conv (
    output col_num,
    output columns,
    output data_valid,
    input  last
  );

  modport shifter (
    input  col_num,
    input  columns,
    input  data_valid,
    output last
  );

endinterface

`default_nettype wire

/* source/hub75_pkg.sv */
`default_nettype none

package hub75_pkg;

  // Red in the top bits, then green, then blue
  localparam int RGB_RES = 9;
  localparam int CH_BITS = RGB_RES / 3;

  // Most significant bit of each colour channel within a pixel
  localparam int R_MSB = RGB_RES - 1;
  localparam int G_MSB = 2 * CH_BITS - 1;
  localparam int B_MSB = CH_BITS - 1;

  typedef logic [RGB_RES-1:0] pixel_t;

  // One half column of pixels, row 0 at index 0
  typedef pixel_t [pov_geom_pkg::NUM_ROWS-1:0] column_t;

  // Slice converter phases
  typedef enum logic [2:0] {
    LOAD,
    SEND_A,
    WAIT_A,
    SEND_B,
    WAIT_B
  } conv_state_t;

endpackage

`default_nettype wire

/* source/pov_geom_pkg.sv */
`default_nettype none

package pov_geom_pkg;

  // Angular slices per revolution of the blade
  localparam int ROT_RES = 1024;

  // Scan addresses of the panel, one per radius
  localparam int SCAN_RATE = 32;

  // Pixels in each half of a panel column
  localparam int NUM_ROWS = 64;

  typedef logic [$clog2(ROT_RES)-1:0] theta_t;

  typedef logic [$clog2(SCAN_RATE)-1:0] radius_t;

  // One bit per row, row 0 in bit 0
  typedef logic [NUM_ROWS-1:0] row_bits_t;

endpackage

`default_nettype wire
